// File: compile.f
design/mem_pkg.sv
design/mem_port_arbiter.sv
design/ifetch_ctrl.sv
design/dmem_ctrl.sv
design/mem_top.sv
sim/clk_gen.sv
sim/mem_model.sv
sim/mem_top_properties.sv
sim/tb_mem_top.sv

// File: design/dmem_ctrl.sv
// data memory controller issuing loads and stores, returning load data in order
`timescale 1ns/1ns

module dmem_ctrl #(
	parameter int MAX_OUTSTANDING = 4
) (
	input  logic                       clk,
	input  logic                       rst,

	input  mem_pkg::data_req_t         data_req_i,
	input  logic                       data_req_valid_i,
	output logic                       data_req_ready_o,

	output mem_pkg::data_rsp_t         data_rsp_o,
	output logic                       data_rsp_valid_o,
	input  logic                       data_rsp_ready_i,

	output mem_pkg::mem_req_t          dmem_req_o,
	input  logic [mem_pkg::TAG_W-1:0]  dmem_accept_i,
	input  logic [63:0]                mem_data_i,
	input  logic [mem_pkg::TAG_W-1:0]  mem_tag_i
);

	import mem_pkg::*;

	localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_OUTSTANDING - 1);

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [63:0]      addr;
	} tq_entry_t;

	// --------------------
	// pending command
	// --------------------
	logic             pend_valid;
	data_req_t        pend_req;

	logic             req_fire;
	logic             issue_fire;
	logic             load_issue;

	// occupancy counts loads only, stores leave nothing behind
	logic [CNT_W:0]   occupancy;

	tq_entry_t        tq_mem [MAX_OUTSTANDING];
	logic [PTR_W-1:0] tq_wr_ptr;
	logic [PTR_W-1:0] tq_rd_ptr;
	logic [CNT_W-1:0] tq_cnt;

	data_rsp_t        rf_mem [MAX_OUTSTANDING];
	logic [PTR_W-1:0] rf_wr_ptr;
	logic [PTR_W-1:0] rf_rd_ptr;
	logic [CNT_W-1:0] rf_cnt;

	logic             capture;
	logic             rsp_fire;

	assign occupancy        = {1'b0, tq_cnt} + {1'b0, rf_cnt};
	assign data_req_ready_o = !pend_valid && (occupancy < (CNT_W+1)'(MAX_OUTSTANDING));
	assign req_fire         = data_req_valid_i && data_req_ready_o;
	assign issue_fire       = pend_valid && (dmem_accept_i != '0);
	assign load_issue       = issue_fire && (pend_req.op == OP_LOAD);

	// commands leave one at a time in request order,
	// so a load never passes an earlier store
	always_comb begin
		if (!pend_valid) begin
			dmem_req_o.cmd = BUS_NONE;
		end else if (pend_req.op == OP_STORE) begin
			dmem_req_o.cmd = BUS_STORE;
		end else begin
			dmem_req_o.cmd = BUS_LOAD;
		end
		dmem_req_o.addr = pend_req.addr;
		dmem_req_o.data = pend_req.wdata;
	end

	// --------------------
	// load return path
	// --------------------
	assign capture          = (tq_cnt != '0) && (mem_tag_i != '0)
		&& (mem_tag_i == tq_mem[tq_rd_ptr].tag);

	assign data_rsp_valid_o = (rf_cnt != '0);
	assign data_rsp_o       = rf_mem[rf_rd_ptr];
	assign rsp_fire         = data_rsp_valid_o && data_rsp_ready_i;

	always_ff @(posedge clk) begin
		if (req_fire) begin
			pend_req <= data_req_i;
		end
		if (load_issue) begin
			tq_mem[tq_wr_ptr] <= '{tag: dmem_accept_i, addr: pend_req.addr};
		end
		if (capture) begin
			rf_mem[rf_wr_ptr] <= '{addr: tq_mem[tq_rd_ptr].addr, data: mem_data_i};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_valid <= 1'b0;
			tq_wr_ptr  <= '0;
			tq_rd_ptr  <= '0;
			tq_cnt     <= '0;
			rf_wr_ptr  <= '0;
			rf_rd_ptr  <= '0;
			rf_cnt     <= '0;
		end else begin
			if (req_fire) begin
				pend_valid <= 1'b1;
			end else if (issue_fire) begin
				pend_valid <= 1'b0;
			end
			if (load_issue) begin
				tq_wr_ptr <= (tq_wr_ptr == LAST_PTR) ? '0 : tq_wr_ptr + 1'b1;
			end
			if (capture) begin
				tq_rd_ptr <= (tq_rd_ptr == LAST_PTR) ? '0 : tq_rd_ptr + 1'b1;
				rf_wr_ptr <= (rf_wr_ptr == LAST_PTR) ? '0 : rf_wr_ptr + 1'b1;
			end
			if (rsp_fire) begin
				rf_rd_ptr <= (rf_rd_ptr == LAST_PTR) ? '0 : rf_rd_ptr + 1'b1;
			end
			case ({load_issue, capture})
				2'b10:   tq_cnt <= tq_cnt + 1'b1;
				2'b01:   tq_cnt <= tq_cnt - 1'b1;
				default: tq_cnt <= tq_cnt;
			endcase
			// buffer never overflows, requests stop at MAX_OUTSTANDING
			case ({capture, rsp_fire})
				2'b10:   rf_cnt <= rf_cnt + 1'b1;
				2'b01:   rf_cnt <= rf_cnt - 1'b1;
				default: rf_cnt <= rf_cnt;
			endcase
		end
	end

endmodule : dmem_ctrl

// File: design/ifetch_ctrl.sv
// instruction fetch controller issuing tagged loads and buffering returned words in order
`timescale 1ns/1ns

module ifetch_ctrl #(
	parameter int MAX_OUTSTANDING = 4
) (
	input  logic                       clk,
	input  logic                       rst,

	input  mem_pkg::fetch_req_t        fetch_req_i,
	input  logic                       fetch_req_valid_i,
	output logic                       fetch_req_ready_o,

	output mem_pkg::fetch_rsp_t        fetch_rsp_o,
	output logic                       fetch_rsp_valid_o,
	input  logic                       fetch_rsp_ready_i,

	output mem_pkg::mem_req_t          imem_req_o,
	input  logic [mem_pkg::TAG_W-1:0]  imem_accept_i,
	input  logic [63:0]                mem_data_i,
	input  logic [mem_pkg::TAG_W-1:0]  mem_tag_i
);

	import mem_pkg::*;

	localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_OUTSTANDING - 1);

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [63:0]      addr;
	} tq_entry_t;

	logic             pend_valid;
	logic [63:0]      pend_addr;

	tq_entry_t        tq_mem [MAX_OUTSTANDING];
	logic [PTR_W-1:0] tq_wr_ptr;
	logic [PTR_W-1:0] tq_rd_ptr;
	logic [CNT_W-1:0] tq_cnt;

	fetch_rsp_t       rf_mem [MAX_OUTSTANDING];
	logic [PTR_W-1:0] rf_wr_ptr;
	logic [PTR_W-1:0] rf_rd_ptr;
	logic [CNT_W-1:0] rf_cnt;

	logic [CNT_W:0]   occupancy;
	logic             req_fire;
	logic             issue_fire;
	logic             capture;
	logic             rsp_fire;

	// loads in flight plus words waiting in the buffer
	assign occupancy         = {1'b0, tq_cnt} + {1'b0, rf_cnt};
	assign fetch_req_ready_o = !pend_valid && (occupancy < (CNT_W+1)'(MAX_OUTSTANDING));
	assign req_fire          = fetch_req_valid_i && fetch_req_ready_o;
	assign issue_fire        = pend_valid && (imem_accept_i != '0);
	// data bus is broadcast, take it only if it is ours and next in order
	assign capture           = (tq_cnt != '0) && (mem_tag_i != '0)
		&& (mem_tag_i == tq_mem[tq_rd_ptr].tag);

	assign fetch_rsp_valid_o = (rf_cnt != '0);
	assign fetch_rsp_o       = rf_mem[rf_rd_ptr];
	assign rsp_fire          = fetch_rsp_valid_o && fetch_rsp_ready_i;

	always_comb begin
		imem_req_o.cmd  = pend_valid ? BUS_LOAD : BUS_NONE;
		imem_req_o.addr = pend_addr;
		imem_req_o.data = '0;
	end

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge clk) begin
		if (req_fire) begin
			pend_addr <= fetch_req_i.addr;
		end
		if (issue_fire) begin
			tq_mem[tq_wr_ptr] <= '{tag: imem_accept_i, addr: pend_addr};
		end
		if (capture) begin
			rf_mem[rf_wr_ptr] <= '{addr: tq_mem[tq_rd_ptr].addr, data: mem_data_i};
		end
	end

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_valid <= 1'b0;
			tq_wr_ptr  <= '0;
			tq_rd_ptr  <= '0;
			tq_cnt     <= '0;
			rf_wr_ptr  <= '0;
			rf_rd_ptr  <= '0;
			rf_cnt     <= '0;
		end else begin
			if (req_fire) begin
				pend_valid <= 1'b1;
			end else if (issue_fire) begin
				pend_valid <= 1'b0;
			end
			if (issue_fire) begin
				tq_wr_ptr <= (tq_wr_ptr == LAST_PTR) ? '0 : tq_wr_ptr + 1'b1;
			end
			if (capture) begin
				tq_rd_ptr <= (tq_rd_ptr == LAST_PTR) ? '0 : tq_rd_ptr + 1'b1;
				rf_wr_ptr <= (rf_wr_ptr == LAST_PTR) ? '0 : rf_wr_ptr + 1'b1;
			end
			if (rsp_fire) begin
				rf_rd_ptr <= (rf_rd_ptr == LAST_PTR) ? '0 : rf_rd_ptr + 1'b1;
			end
			case ({issue_fire, capture})
				2'b10:   tq_cnt <= tq_cnt + 1'b1;
				2'b01:   tq_cnt <= tq_cnt - 1'b1;
				default: tq_cnt <= tq_cnt;
			endcase
			case ({capture, rsp_fire})
				2'b10:   rf_cnt <= rf_cnt + 1'b1;
				2'b01:   rf_cnt <= rf_cnt - 1'b1;
				default: rf_cnt <= rf_cnt;
			endcase
		end
	end

endmodule : ifetch_ctrl

// File: design/mem_pkg.sv
// shared types for the fetch/data memory port: commands, operations and channel structs
package mem_pkg;

	// --------------------
	// memory port encodings
	// --------------------

	// memory tag width, tag 0 means rejected or no data
	localparam int TAG_W = 4;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_LOAD  = 2'd1,
		BUS_STORE = 2'd2
	} mem_cmd_e;

	// data side operation
	typedef enum logic {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} data_op_e;

	// --------------------
	// memory port structs
	// --------------------

	// command to memory
	typedef struct packed {
		mem_cmd_e    cmd;
		logic [63:0] addr;
		logic [63:0] data;
	} mem_req_t;

	// everything the memory returns
	typedef struct packed {
		logic [TAG_W-1:0] response;
		logic [63:0]      data;
		logic [TAG_W-1:0] tag;
	} mem_rsp_t;

	// --------------------
	// core side channels
	// --------------------

	typedef struct packed {
		logic [63:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic [63:0] addr;
		logic [63:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		data_op_e    op;
		logic [63:0] addr;
		logic [63:0] wdata;
	} data_req_t;

	// load results only
	typedef struct packed {
		logic [63:0] addr;
		logic [63:0] data;
	} data_rsp_t;

endpackage : mem_pkg

// File: design/mem_port_arbiter.sv
// rotating-priority arbiter sharing the memory port between fetch and data commands
`timescale 1ns/1ns

module mem_port_arbiter #(
	parameter int ARB_PERIOD = 2
) (
	input  logic                       clk,
	input  logic                       rst,

	input  mem_pkg::mem_req_t          imem_req_i,
	input  mem_pkg::mem_req_t          dmem_req_i,
	input  logic [mem_pkg::TAG_W-1:0]  mem_response_i,

	output mem_pkg::mem_req_t          mem_req_o,
	output logic [mem_pkg::TAG_W-1:0]  imem_accept_o,
	output logic [mem_pkg::TAG_W-1:0]  dmem_accept_o
);

	import mem_pkg::*;

	// bit 0 set means the instruction side has priority this cycle
	logic [ARB_PERIOD-1:0] arb_vec_r;

	logic imem_active;
	logic dmem_active;
	logic imem_wins;

	assign imem_active = (imem_req_i.cmd != BUS_NONE);
	assign dmem_active = (dmem_req_i.cmd != BUS_NONE);

	// priority side wins if it has something, else the other side
	always_comb begin
		if (arb_vec_r[0]) begin
			imem_wins = imem_active;
		end else begin
			imem_wins = !dmem_active;
		end
	end

	// --------------------
	// command mux
	// --------------------
	always_comb begin
		if (imem_wins) begin
			mem_req_o.cmd  = imem_req_i.cmd;
			mem_req_o.addr = imem_req_i.addr;
		end else begin
			mem_req_o.cmd  = dmem_req_i.cmd;
			mem_req_o.addr = dmem_req_i.addr;
		end
		// only the data side writes memory
		mem_req_o.data = dmem_req_i.data;
	end

	// --------------------
	// response routing
	// --------------------

	// the loser sees zero and retries next cycle
	always_comb begin
		imem_accept_o = '0;
		dmem_accept_o = '0;
		if (imem_wins && imem_active) begin
			imem_accept_o = mem_response_i;
		end
		if (!imem_wins && dmem_active) begin
			dmem_accept_o = mem_response_i;
		end
	end

	// one-hot rotation over the window
	always_ff @(posedge clk) begin
		if (rst) begin
			arb_vec_r <= ARB_PERIOD'(1);
		end else begin
			arb_vec_r <= (arb_vec_r >> 1)
				| (ARB_PERIOD'(arb_vec_r[0]) << (ARB_PERIOD - 1));
		end
	end

endmodule : mem_port_arbiter

// File: design/mem_top.sv
// memory side top level: fetch and data controllers sharing one tagged memory port
`timescale 1ns/1ns

module mem_top #(
	parameter int ARB_PERIOD      = 2,
	parameter int MAX_OUTSTANDING = 4
) (
	input  logic                 clk,
	input  logic                 rst,

	// fetch channel
	input  mem_pkg::fetch_req_t  fetch_req_i,
	input  logic                 fetch_req_valid_i,
	output logic                 fetch_req_ready_o,
	output mem_pkg::fetch_rsp_t  fetch_rsp_o,
	output logic                 fetch_rsp_valid_o,
	input  logic                 fetch_rsp_ready_i,

	// data channel
	input  mem_pkg::data_req_t   data_req_i,
	input  logic                 data_req_valid_i,
	output logic                 data_req_ready_o,
	output mem_pkg::data_rsp_t   data_rsp_o,
	output logic                 data_rsp_valid_o,
	input  logic                 data_rsp_ready_i,

	// memory port
	output mem_pkg::mem_req_t    mem_req_o,
	input  mem_pkg::mem_rsp_t    mem_rsp_i
);

	import mem_pkg::*;

	mem_req_t         imem_req;
	mem_req_t         dmem_req;
	logic [TAG_W-1:0] imem_accept;
	logic [TAG_W-1:0] dmem_accept;

	ifetch_ctrl #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) u_ifetch_ctrl (
		.clk               (clk),
		.rst               (rst),
		.fetch_req_i       (fetch_req_i),
		.fetch_req_valid_i (fetch_req_valid_i),
		.fetch_req_ready_o (fetch_req_ready_o),
		.fetch_rsp_o       (fetch_rsp_o),
		.fetch_rsp_valid_o (fetch_rsp_valid_o),
		.fetch_rsp_ready_i (fetch_rsp_ready_i),
		.imem_req_o        (imem_req),
		.imem_accept_i     (imem_accept),
		.mem_data_i        (mem_rsp_i.data),
		.mem_tag_i         (mem_rsp_i.tag)
	);

	dmem_ctrl #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) u_dmem_ctrl (
		.clk              (clk),
		.rst              (rst),
		.data_req_i       (data_req_i),
		.data_req_valid_i (data_req_valid_i),
		.data_req_ready_o (data_req_ready_o),
		.data_rsp_o       (data_rsp_o),
		.data_rsp_valid_o (data_rsp_valid_o),
		.data_rsp_ready_i (data_rsp_ready_i),
		.dmem_req_o       (dmem_req),
		.dmem_accept_i    (dmem_accept),
		.mem_data_i       (mem_rsp_i.data),
		.mem_tag_i        (mem_rsp_i.tag)
	);

	// data and tag lines are broadcast, only the accept is arbitrated
	mem_port_arbiter #(
		.ARB_PERIOD (ARB_PERIOD)
	) u_mem_port_arbiter (
		.clk            (clk),
		.rst            (rst),
		.imem_req_i     (imem_req),
		.dmem_req_i     (dmem_req),
		.mem_response_i (mem_rsp_i.response),
		.mem_req_o      (mem_req_o),
		.imem_accept_o  (imem_accept),
		.dmem_accept_o  (dmem_accept)
	);

endmodule : mem_top

// File: run.sh
#!/usr/bin/env bash
# build and run the memory port testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_top \
	-f compile.f -o tb_mem_top \
	&& ./obj_dir/tb_mem_top 2>&1 | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }

grep -q "Finished with no errors" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// File: sim/clk_gen.sv
// clock and reset source for the memory port testbench
`timescale 1ns/1ns

module clk_gen #(
	parameter int HALF_PERIOD = 5,
	parameter int RST_CYCLES  = 10
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// reset drops at the edge that closes the last reset cycle
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule : clk_gen

// File: sim/mem_model.sv
// behavioral tagged memory with a fixed load latency and a switch to reject commands
`timescale 1ns/1ns

module mem_model #(
	parameter int          LATENCY = 3,
	parameter logic [63:0] FILL    = 64'h0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              reject_i,
	input  mem_pkg::mem_req_t mem_req_i,
	output mem_pkg::mem_rsp_t mem_rsp_o
);

	import mem_pkg::*;

	localparam int MAX_TAGS = (1 << TAG_W) - 1;

	logic [63:0]      store_mem [logic [63:0]];
	logic [TAG_W-1:0] next_tag;
	int               inflight;
	logic             accept;
	logic             load_accept;
	logic             load_return;

	// in-flight loads, the last stage drives the data bus
	logic [TAG_W-1:0] pipe_tag  [LATENCY];
	logic [63:0]      pipe_data [LATENCY];

	// untouched words hold their address xor the fill pattern
	function automatic logic [63:0] read_word(input logic [63:0] addr);
		logic [63:0] word;
		if (store_mem.exists(addr)) begin
			word = store_mem[addr];
		end else begin
			word = addr ^ FILL;
		end
		return word;
	endfunction

	assign accept      = (mem_req_i.cmd != BUS_NONE) && !reject_i && (inflight < MAX_TAGS);
	assign load_accept = accept && (mem_req_i.cmd == BUS_LOAD);
	assign load_return = (pipe_tag[LATENCY-1] != '0);

	always_comb begin
		mem_rsp_o.response = accept ? next_tag : '0;
		mem_rsp_o.data     = pipe_data[LATENCY-1];
		mem_rsp_o.tag      = pipe_tag[LATENCY-1];
	end

	// stores land at acceptance so a later load sees them
	always @(posedge clk) begin
		if (!rst && accept && (mem_req_i.cmd == BUS_STORE)) begin
			store_mem[mem_req_i.addr] = mem_req_i.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			next_tag <= TAG_W'(1);
			inflight <= 0;
			for (int i = 0; i < LATENCY; i++) begin
				pipe_tag[i]  <= '0;
				pipe_data[i] <= '0;
			end
		end else begin
			for (int i = LATENCY - 1; i > 0; i--) begin
				pipe_tag[i]  <= pipe_tag[i-1];
				pipe_data[i] <= pipe_data[i-1];
			end
			pipe_tag[0]  <= load_accept ? next_tag : '0;
			pipe_data[0] <= load_accept ? read_word(mem_req_i.addr) : '0;
			// tags run 1 to 15, zero is never handed out
			if (accept) begin
				next_tag <= (next_tag == TAG_W'(MAX_TAGS)) ? TAG_W'(1) : next_tag + 1'b1;
			end
			inflight <= inflight + (load_accept ? 1 : 0) - (load_return ? 1 : 0);
		end
	end

endmodule : mem_model

// File: sim/mem_top_properties.sv
// handshake assertions for the memory side top level, bound into mem_top
`timescale 1ns/1ns

module mem_top_properties (
	input logic                       clk,
	input logic                       rst,
	input mem_pkg::fetch_rsp_t        fetch_rsp_i,
	input logic                       fetch_rsp_valid_i,
	input logic                       fetch_rsp_ready_i,
	input mem_pkg::data_rsp_t         data_rsp_i,
	input logic                       data_rsp_valid_i,
	input logic                       data_rsp_ready_i,
	input mem_pkg::mem_req_t          mem_req_i,
	input mem_pkg::mem_req_t          imem_req_i,
	input logic [mem_pkg::TAG_W-1:0]  imem_accept_i,
	input mem_pkg::mem_req_t          dmem_req_i,
	input logic [mem_pkg::TAG_W-1:0]  dmem_accept_i
);

	import mem_pkg::*;

	// --------------------
	// response channels
	// --------------------
	fetch_rsp_hold : assert property (@(posedge clk) disable iff (rst)
		fetch_rsp_valid_i && !fetch_rsp_ready_i |=> fetch_rsp_valid_i && $stable(fetch_rsp_i))
		else $error("fetch response changed before it was taken");

	data_rsp_hold : assert property (@(posedge clk) disable iff (rst)
		data_rsp_valid_i && !data_rsp_ready_i |=> data_rsp_valid_i && $stable(data_rsp_i))
		else $error("data response changed before it was taken");

	// port is idle once reset has been seen
	idle_after_reset : assert property (@(posedge clk)
		rst |=> mem_req_i.cmd == BUS_NONE)
		else $error("memory command active right after reset");

	// --------------------
	// retried commands
	// --------------------
	imem_cmd_hold : assert property (@(posedge clk) disable iff (rst)
		imem_req_i.cmd != BUS_NONE && imem_accept_i == '0 |=> $stable(imem_req_i))
		else $error("fetch command changed before acceptance");

	dmem_cmd_hold : assert property (@(posedge clk) disable iff (rst)
		dmem_req_i.cmd != BUS_NONE && dmem_accept_i == '0 |=> $stable(dmem_req_i))
		else $error("data command changed before acceptance");

endmodule : mem_top_properties

bind mem_top mem_top_properties u_mem_top_properties (
	.clk               (clk),
	.rst               (rst),
	.fetch_rsp_i       (fetch_rsp_o),
	.fetch_rsp_valid_i (fetch_rsp_valid_o),
	.fetch_rsp_ready_i (fetch_rsp_ready_i),
	.data_rsp_i        (data_rsp_o),
	.data_rsp_valid_i  (data_rsp_valid_o),
	.data_rsp_ready_i  (data_rsp_ready_i),
	.mem_req_i         (mem_req_o),
	.imem_req_i        (imem_req),
	.imem_accept_i     (imem_accept),
	.dmem_req_i        (dmem_req),
	.dmem_accept_i     (dmem_accept)
);

// File: sim/tb_mem_top.sv
// directed testbench for the shared fetch and data memory port
`timescale 1ns/1ns

module tb_mem_top;

	import mem_pkg::*;

	localparam int          ARB_PERIOD      = 2;
	localparam int          MAX_OUTSTANDING = 4;
	localparam int          TIMEOUT         = 200;
	localparam logic [63:0] FILL            = 64'hA5C3_0F1E_9B7D_4268;
	localparam logic [63:0] FETCH_BASE      = 64'h0000_1000;
	localparam logic [63:0] DATA_BASE       = 64'h0000_2000;

	logic       clk;
	logic       rst;
	fetch_req_t fetch_req;
	logic       fetch_req_valid;
	logic       fetch_req_ready;
	fetch_rsp_t fetch_rsp;
	logic       fetch_rsp_valid;
	logic       fetch_rsp_ready;
	data_req_t  data_req;
	logic       data_req_valid;
	logic       data_req_ready;
	data_rsp_t  data_rsp;
	logic       data_rsp_valid;
	logic       data_rsp_ready;
	mem_req_t   mem_req;
	mem_rsp_t   mem_rsp;
	logic       reject;
	int         seed;

	// reference image holds only written words
	logic [63:0] image [logic [63:0]];

	fetch_rsp_t fetch_exp [$];
	fetch_rsp_t fetch_got [$];
	data_rsp_t  data_exp [$];
	data_rsp_t  data_got [$];

	clk_gen #(
		.HALF_PERIOD (5),
		.RST_CYCLES  (10)
	) u_clk_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	mem_model #(
		.LATENCY (3),
		.FILL    (FILL)
	) u_mem_model (
		.clk       (clk),
		.rst       (rst),
		.reject_i  (reject),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp)
	);

	mem_top #(
		.ARB_PERIOD      (ARB_PERIOD),
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) UUT (
		.clk               (clk),
		.rst               (rst),
		.fetch_req_i       (fetch_req),
		.fetch_req_valid_i (fetch_req_valid),
		.fetch_req_ready_o (fetch_req_ready),
		.fetch_rsp_o       (fetch_rsp),
		.fetch_rsp_valid_o (fetch_rsp_valid),
		.fetch_rsp_ready_i (fetch_rsp_ready),
		.data_req_i        (data_req),
		.data_req_valid_i  (data_req_valid),
		.data_req_ready_o  (data_req_ready),
		.data_rsp_o        (data_rsp),
		.data_rsp_valid_o  (data_rsp_valid),
		.data_rsp_ready_i  (data_rsp_ready),
		.mem_req_o         (mem_req),
		.mem_rsp_i         (mem_rsp)
	);

	// --------------------
	// reporting
	// --------------------
	task automatic stop_with_errors();
		$display("Finished with errors");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic fail_with(input string what);
		$display("Error: %s", what);
		stop_with_errors();
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			stop_with_errors();
		end
	endtask

	function automatic logic [63:0] ref_word(input logic [63:0] addr);
		logic [63:0] word;
		if (image.exists(addr)) begin
			word = image[addr];
		end else begin
			word = addr ^ FILL;
		end
		return word;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// a transfer happens at the next edge if valid and ready are both high now
	always @(negedge clk) begin
		if (!rst && fetch_rsp_valid && fetch_rsp_ready) begin
			fetch_got.push_back(fetch_rsp);
		end
		if (!rst && data_rsp_valid && data_rsp_ready) begin
			data_got.push_back(data_rsp);
		end
	end

	// --------------------
	// request drivers
	// --------------------
	task automatic drive_fetch(input logic [63:0] addr);
		fetch_rsp_t exp;
		exp.addr = addr;
		exp.data = ref_word(addr);
		fetch_exp.push_back(exp);
		fetch_req.addr  = addr;
		fetch_req_valid = 1'b1;
	endtask

	task automatic await_fetch_accept();
		int waited;
		waited = 0;
		while (!fetch_req_ready) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT) begin
				fail_with("fetch request was not accepted in time");
			end
		end
		next_cycle();
		fetch_req_valid = 1'b0;
	endtask

	task automatic send_fetch(input logic [63:0] addr);
		drive_fetch(addr);
		await_fetch_accept();
	endtask

	task automatic send_data(input data_op_e op, input logic [63:0] addr,
		input logic [63:0] wdata);
		data_rsp_t exp;
		int        waited;
		// data side is in order, so the image follows program order
		if (op == OP_STORE) begin
			image[addr] = wdata;
		end else begin
			exp.addr = addr;
			exp.data = ref_word(addr);
			data_exp.push_back(exp);
		end
		data_req.op    = op;
		data_req.addr  = addr;
		data_req.wdata = wdata;
		data_req_valid = 1'b1;
		waited = 0;
		while (!data_req_ready) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT) begin
				fail_with("data request was not accepted in time");
			end
		end
		next_cycle();
		data_req_valid = 1'b0;
	endtask

	// --------------------
	// response checking
	// --------------------
	task automatic compare_fetch();
		fetch_rsp_t got;
		fetch_rsp_t exp;
		if (fetch_exp.size() == 0) begin
			fail_with("fetch response arrived with no fetch outstanding");
		end
		got = fetch_got.pop_front();
		exp = fetch_exp.pop_front();
		check_value("fetch_rsp_o.addr", got.addr, exp.addr);
		check_value("fetch_rsp_o.data", got.data, exp.data);
	endtask

	task automatic compare_data();
		data_rsp_t got;
		data_rsp_t exp;
		if (data_exp.size() == 0) begin
			fail_with("data response arrived with no load outstanding");
		end
		got = data_got.pop_front();
		exp = data_exp.pop_front();
		check_value("data_rsp_o.addr", got.addr, exp.addr);
		check_value("data_rsp_o.data", got.data, exp.data);
	endtask

	task automatic drain_responses();
		int idle;
		idle = 0;
		while (fetch_exp.size() != 0 || data_exp.size() != 0) begin
			if (fetch_got.size() != 0) begin
				compare_fetch();
				idle = 0;
			end else if (data_got.size() != 0) begin
				compare_data();
				idle = 0;
			end else begin
				next_cycle();
				idle++;
				if (idle > TIMEOUT) begin
					if (fetch_exp.size() != 0) begin
						fail_with("fetch responses stopped arriving");
					end else begin
						fail_with("data responses stopped arriving");
					end
				end
			end
		end
		check_value("extra fetch responses", 64'(fetch_got.size()), 64'd0);
		check_value("extra data responses", 64'(data_got.size()), 64'd0);
	endtask

	task automatic check_idle_outputs();
		check_value("mem_req_o.cmd", 64'(mem_req.cmd), 64'(BUS_NONE));
		check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid), 64'd0);
		check_value("data_rsp_valid_o", 64'(data_rsp_valid), 64'd0);
		check_value("fetch_req_ready_o", 64'(fetch_req_ready), 64'd1);
		check_value("data_req_ready_o", 64'(data_req_ready), 64'd1);
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic reset_state_test();
		int waited;
		waited = 0;
		next_cycle();
		while (rst) begin
			check_idle_outputs();
			next_cycle();
			waited++;
			if (waited > 20) begin
				fail_with("reset was never released");
			end
		end
		check_idle_outputs();
	endtask

	task automatic fetch_stream_test();
		for (int i = 0; i < 8; i++) begin
			send_fetch(FETCH_BASE + 64'(i * 8));
		end
		drain_responses();
	endtask

	task automatic store_load_test();
		for (int i = 0; i < 4; i++) begin
			send_data(OP_STORE, DATA_BASE + 64'(i * 8), 64'hFACE_0000_0000_0000 ^ 64'(i * 17));
		end
		for (int i = 0; i < 4; i++) begin
			send_data(OP_LOAD, DATA_BASE + 64'(i * 8), 64'd0);
		end
		drain_responses();
	endtask

	// both channels at once and neither may starve
	task automatic shared_port_test();
		fork
			begin
				for (int i = 0; i < 8; i++) begin
					send_fetch(FETCH_BASE + 64'h100 + 64'(i * 8));
				end
			end
			begin
				for (int j = 0; j < 8; j++) begin
					send_data(OP_LOAD, DATA_BASE + 64'(j * 8), 64'd0);
				end
			end
		join
		drain_responses();
	endtask

	task automatic backpressure_test();
		fetch_rsp_ready = 1'b0;
		data_rsp_ready  = 1'b0;
		// load words wait in the data buffer meanwhile
		send_data(OP_LOAD, DATA_BASE + 64'h200, 64'd0);
		send_data(OP_LOAD, DATA_BASE + 64'h208, 64'd0);
		for (int i = 0; i < MAX_OUTSTANDING; i++) begin
			send_fetch(FETCH_BASE + 64'h200 + 64'(i * 8));
		end
		// one beyond the limit must wait
		drive_fetch(FETCH_BASE + 64'h200 + 64'(MAX_OUTSTANDING * 8));
		for (int n = 0; n < 20; n++) begin
			next_cycle();
			check_value("fetch_req_ready_o", 64'(fetch_req_ready), 64'd0);
		end
		check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid), 64'd1);
		check_value("data_rsp_valid_o", 64'(data_rsp_valid), 64'd1);
		fetch_rsp_ready = 1'b1;
		data_rsp_ready  = 1'b1;
		await_fetch_accept();
		drain_responses();
	endtask

	task automatic reject_retry_test();
		fork
			begin
				reject = 1'b1;
				repeat (15) next_cycle();
				check_value("mem_req_o.cmd active", 64'(mem_req.cmd != BUS_NONE), 64'd1);
				reject = 1'b0;
			end
			begin
				for (int i = 0; i < 3; i++) begin
					send_fetch(FETCH_BASE + 64'h300 + 64'(i * 8));
				end
			end
			begin
				send_data(OP_STORE, DATA_BASE + 64'h100, 64'h0123_4567_89AB_CDEF);
				send_data(OP_LOAD, DATA_BASE + 64'h100, 64'd0);
				send_data(OP_LOAD, DATA_BASE + 64'h108, 64'd0);
			end
		join
		drain_responses();
	endtask

	task automatic random_mix_test();
		int          kinds [40];
		logic [63:0] offs [40];
		logic [63:0] wdata [40];
		seed = 84;
		for (int i = 0; i < 40; i++) begin
			kinds[i] = $random(seed) & 3;
			offs[i]  = 64'(($random(seed) & 7) * 8);
			wdata[i] = {$random(seed), $random(seed)};
		end
		// kinds are 0 fetch, 2 store and 1 or 3 load
		fork
			begin
				for (int i = 0; i < 40; i++) begin
					if (kinds[i] == 0) begin
						send_fetch(FETCH_BASE + offs[i]);
					end
				end
			end
			begin
				for (int j = 0; j < 40; j++) begin
					if (kinds[j] == 2) begin
						send_data(OP_STORE, DATA_BASE + offs[j], wdata[j]);
					end else if (kinds[j] != 0) begin
						send_data(OP_LOAD, DATA_BASE + offs[j], 64'd0);
					end
				end
			end
		join
		drain_responses();
	endtask

	initial begin
		int cycles;
		for (cycles = 0; cycles < 50000; cycles++) begin
			@(posedge clk);
		end
		fail_with("simulation did not finish in time");
	end

	initial begin
		fetch_req       = '0;
		fetch_req_valid = 1'b0;
		fetch_rsp_ready = 1'b1;
		data_req        = '0;
		data_req_valid  = 1'b0;
		data_rsp_ready  = 1'b1;
		reject          = 1'b0;
		seed            = 84;

		reset_state_test();
		fetch_stream_test();
		store_load_test();
		shared_port_test();
		backpressure_test();
		reject_retry_test();
		random_mix_test();

		$display("Finished with no errors");
		$finish;
	end

endmodule : tb_mem_top
